//--- all.f
+incdir+include
src/mm_ram_pkg.sv
src/dp_ram.sv
src/mm_addr_decoder.sv
src/mm_ctrl_regs.sv
src/irq_timer.sv
src/debug_req_gen.sv
src/mm_ram.sv
verification/mm_ram_tb.sv

//--- verification/mm_ram_tb.sv
// Testbench for the memory model
// Directed tests for RAM access, instruction fetch, debug remap, status
// and exit words, the timer interrupt and the debug request generator

`timescale 1ns/1ps
`include "mm_ram_config.svh"

module mm_ram_tb;

    import mm_ram_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int TIMEOUT_CYCLES = 200;
    localparam word_t DM_HALT_ADDR = 32'h1A11_0800;
    localparam word_t DBG_RAM_BASE =
        word_t'(2**`MM_RAM_ADDR_WIDTH - 2**`MM_DBG_ADDR_WIDTH);
    localparam int TIMER_COUNT = 7;

    logic        clk_i;
    logic        rst_ni;
    word_t       dm_halt_addr_i;
    logic        instr_req_i;
    word_t       instr_addr_i;
    instr_line_t instr_rdata_o;
    logic        instr_rvalid_o;
    logic        instr_gnt_o;
    logic        data_req_i;
    word_t       data_addr_i;
    logic        data_we_i;
    byte_en_t    data_be_i;
    word_t       data_wdata_i;
    word_t       data_rdata_o;
    logic        data_rvalid_o;
    logic        data_gnt_o;
    irq_id_t     irq_id_i;
    logic        irq_ack_i;
    irq_vec_t    irq_o;
    logic        debug_req_o;
    logic        tests_passed_o;
    logic        tests_failed_o;
    logic        exit_valid_o;
    word_t       exit_value_o;

    // status pulses seen in the cycle of the last data request
    logic  seen_passed;
    logic  seen_failed;
    logic  seen_exit;
    word_t seen_exit_value;

    mm_ram mm_ram_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .dm_halt_addr_i (dm_halt_addr_i),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_rdata_o  (instr_rdata_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_gnt_o    (instr_gnt_o),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_wdata_i   (data_wdata_i),
        .data_rdata_o   (data_rdata_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_gnt_o     (data_gnt_o),
        .irq_id_i       (irq_id_i),
        .irq_ack_i      (irq_ack_i),
        .irq_o          (irq_o),
        .debug_req_o    (debug_req_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string test_name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("ERROR %s: expected %0h actual %0h",
                                        test_name, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #(DRIVE_DELAY);
    endtask

    // old bytes survive where the byte enable is low
    function automatic word_t merge_bytes(word_t old_word, word_t new_word, byte_en_t be);
        word_t merged;
        merged = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // 31 level, 30 pulse, 28:16 width, 14:0 delay
    function automatic word_t debug_cmd(logic level, logic pulse, dbg_width_t width,
                                        dbg_delay_t delay);
        return {level, pulse, 1'b0, width, 1'b0, delay};
    endfunction

    // one request, then the response, then one idle cycle
    task automatic data_access(input string test_name, input word_t addr, input logic we,
                               input byte_en_t be, input word_t wdata, output word_t rdata);
        int waited;
        data_req_i = 1'b1;
        data_addr_i = addr;
        data_we_i = we;
        data_be_i = be;
        data_wdata_i = wdata;
        #1;
        check_value({test_name, " data_gnt_o"}, 1, data_gnt_o);
        seen_passed = tests_passed_o;
        seen_failed = tests_failed_o;
        seen_exit = exit_valid_o;
        seen_exit_value = exit_value_o;
        next_cycle();
        data_req_i = 1'b0;
        data_we_i = 1'b0;
        waited = 1;
        while (!data_rvalid_o && waited < TIMEOUT_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (!data_rvalid_o) begin
            stop_with_failure({test_name, ": data_rvalid_o never came"});
        end
        check_value({test_name, " rvalid latency"}, 1, waited);
        rdata = data_rdata_o;
        next_cycle();
        check_value({test_name, " rvalid pulse"}, 0, data_rvalid_o);
    endtask

    task automatic write_word(input string test_name, input word_t addr, input byte_en_t be,
                              input word_t wdata);
        word_t unused;
        data_access(test_name, addr, 1'b1, be, wdata, unused);
    endtask

    task automatic read_word(input string test_name, input word_t addr, output word_t rdata);
        data_access(test_name, addr, 1'b0, 4'hF, '0, rdata);
    endtask

    task automatic fetch_line(input string test_name, input word_t addr,
                              output instr_line_t line);
        int waited;
        instr_req_i = 1'b1;
        instr_addr_i = addr;
        #1;
        check_value({test_name, " instr_gnt_o"}, 1, instr_gnt_o);
        next_cycle();
        instr_req_i = 1'b0;
        waited = 1;
        while (!instr_rvalid_o && waited < TIMEOUT_CYCLES) begin
            next_cycle();
            waited++;
        end
        if (!instr_rvalid_o) begin
            stop_with_failure({test_name, ": instr_rvalid_o never came"});
        end
        check_value({test_name, " rvalid latency"}, 1, waited);
        line = instr_rdata_o;
        next_cycle();
        check_value({test_name, " rvalid pulse"}, 0, instr_rvalid_o);
    endtask

    // counts edges, starting from the given number, until the level shows
    task automatic wait_for_debug(input logic level, input int start, output int edges);
        edges = start;
        while (debug_req_o !== level && edges < TIMEOUT_CYCLES) begin
            next_cycle();
            edges++;
        end
        if (debug_req_o !== level) begin
            stop_with_failure("debug_req_o never reached the requested level");
        end
    endtask

    task automatic wait_for_irq(input int start, output int edges);
        edges = start;
        while (irq_o == '0 && edges < TIMEOUT_CYCLES) begin
            next_cycle();
            edges++;
        end
        if (irq_o == '0) begin
            stop_with_failure("irq_o stayed zero after the timer was loaded");
        end
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------

    task automatic check_reset_state();
        check_value("reset data_rvalid_o", 0, data_rvalid_o);
        check_value("reset instr_rvalid_o", 0, instr_rvalid_o);
        check_value("reset irq_o", 0, irq_o);
        check_value("reset debug_req_o", 0, debug_req_o);
        check_value("reset tests_passed_o", 0, tests_passed_o);
        check_value("reset tests_failed_o", 0, tests_failed_o);
        check_value("reset exit_valid_o", 0, exit_valid_o);
    endtask

    task automatic test_ram_access();
        word_t addr;
        word_t old_word;
        word_t new_word;
        word_t rdata;
        byte_en_t be;
        for (int i = 0; i < 8; i++) begin
            // stay in the lower 16 KiB
            addr = word_t'(($urandom() % 32'h1000) * 4);
            old_word = $urandom();
            new_word = $urandom();
            be = byte_en_t'($urandom());
            write_word("ram_access", addr, 4'hF, old_word);
            write_word("ram_access", addr, be, new_word);
            read_word("ram_access", addr, rdata);
            check_value("ram_access", merge_bytes(old_word, new_word, be), rdata);
        end
        write_word("ram_access unmapped write", 32'h3000_0000, 4'hF, $urandom());
        read_word("ram_access unmapped read", 32'h3000_0000, rdata);
        check_value("ram_access unmapped read", 0, rdata);
        read_word("ram_access peripheral read", `MM_ADDR_TIMER_VAL, rdata);
        check_value("ram_access peripheral read", 0, rdata);
    endtask

    task automatic test_instr_fetch();
        word_t words [4];
        instr_line_t line;
        for (int i = 0; i < 4; i++) begin
            words[i] = $urandom();
            write_word("instr_fetch", 32'h0000_0200 + word_t'(4*i), 4'hF, words[i]);
        end
        fetch_line("instr_fetch", 32'h0000_0200, line);
        check_value("instr_fetch", {words[3], words[2], words[1], words[0]}, line);
        fetch_line("instr_fetch unaligned", 32'h0000_0208, line);
        check_value("instr_fetch unaligned", {words[3], words[2], words[1], words[0]}, line);
    endtask

    task automatic test_debug_remap();
        word_t value;
        word_t rdata;
        instr_line_t line;
        value = $urandom();
        write_word("debug_remap write", DM_HALT_ADDR + 32'h40, 4'hF, value);
        read_word("debug_remap read", DBG_RAM_BASE + 32'h40, rdata);
        check_value("debug_remap to ram", value, rdata);
        fetch_line("debug_remap fetch", DM_HALT_ADDR + 32'h40, line);
        check_value("debug_remap fetch", value, line[31:0]);
        value = $urandom();
        write_word("debug_remap write", DBG_RAM_BASE + 32'h84, 4'hF, value);
        read_word("debug_remap read", DM_HALT_ADDR + 32'h84, rdata);
        check_value("debug_remap from ram", value, rdata);
    endtask

    task automatic test_status_exit();
        word_t value;
        write_word("status pass", `MM_ADDR_STATUS, 4'hF, `MM_PASS_CODE);
        check_value("status pass tests_passed_o", 1, seen_passed);
        check_value("status pass tests_failed_o", 0, seen_failed);
        write_word("status fail", `MM_ADDR_STATUS, 4'hF, `MM_FAIL_CODE);
        check_value("status fail tests_passed_o", 0, seen_passed);
        check_value("status fail tests_failed_o", 1, seen_failed);
        write_word("status other", `MM_ADDR_STATUS, 4'hF, 32'd42);
        check_value("status other tests_passed_o", 0, seen_passed);
        check_value("status other tests_failed_o", 0, seen_failed);
        check_value("status other exit_valid_o", 0, seen_exit);
        value = $urandom();
        write_word("exit", `MM_ADDR_EXIT, 4'hF, value);
        check_value("exit exit_valid_o", 1, seen_exit);
        check_value("exit exit_value_o", value, seen_exit_value);
        check_value("exit pulse ended", 0, exit_valid_o);
    endtask

    task automatic test_timer_irq();
        irq_vec_t mask;
        irq_vec_t expected;
        int edges;
        mask = irq_vec_t'($urandom()) | irq_vec_t'(32'h0000_0100);
        check_value("timer idle", 0, irq_o);
        write_word("timer mask", `MM_ADDR_TIMER_MASK, 4'hF, mask);
        write_word("timer count", `MM_ADDR_TIMER_VAL, 4'hF, word_t'(TIMER_COUNT));
        // write_word returns one edge after the accepting edge
        wait_for_irq(1, edges);
        check_value("timer delay", TIMER_COUNT, edges);
        check_value("timer vector", mask, irq_o);
        irq_ack_i = 1'b1;
        irq_id_i = irq_id_t'(8);
        next_cycle();
        irq_ack_i = 1'b0;
        irq_id_i = '0;
        expected = mask & ~irq_vec_t'(32'h0000_0100);
        check_value("timer ack", expected, irq_o);
        next_cycle();
        check_value("timer ack hold", expected, irq_o);
    endtask

    task automatic test_debug_req();
        int edges;
        check_value("debug idle", 0, debug_req_o);
        write_word("debug level", `MM_ADDR_DEBUG, 4'hF, debug_cmd(1'b1, 1'b0, 13'd0, 15'd5));
        wait_for_debug(1'b1, 1, edges);
        check_value("debug level delay", 5, edges);
        // zero delay acts as a delay of one
        write_word("debug low", `MM_ADDR_DEBUG, 4'hF, debug_cmd(1'b0, 1'b0, 13'd0, 15'd0));
        wait_for_debug(1'b0, 1, edges);
        check_value("debug low delay", 1, edges);
        write_word("debug pulse", `MM_ADDR_DEBUG, 4'hF, debug_cmd(1'b1, 1'b1, 13'd6, 15'd4));
        wait_for_debug(1'b1, 1, edges);
        check_value("debug pulse delay", 4, edges);
        wait_for_debug(1'b0, 0, edges);
        check_value("debug pulse width", 6, edges);
        // second command lands while the first one is counting
        write_word("debug busy", `MM_ADDR_DEBUG, 4'hF, debug_cmd(1'b1, 1'b1, 13'd3, 15'd8));
        write_word("debug ignored", `MM_ADDR_DEBUG, 4'hF, debug_cmd(1'b1, 1'b0, 13'd0, 15'd2));
        wait_for_debug(1'b1, 3, edges);
        check_value("debug busy delay", 8, edges);
        wait_for_debug(1'b0, 0, edges);
        check_value("debug busy width", 3, edges);
        for (int i = 0; i < 10; i++) begin
            next_cycle();
            check_value("debug ignored stays low", 0, debug_req_o);
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------

    initial begin
        void'($urandom(32'h3588));
        clk_i = 1'b0;
        rst_ni = 1'b0;
        dm_halt_addr_i = DM_HALT_ADDR;
        instr_req_i = 1'b0;
        instr_addr_i = '0;
        data_req_i = 1'b0;
        data_addr_i = '0;
        data_we_i = 1'b0;
        data_be_i = '0;
        data_wdata_i = '0;
        irq_id_i = '0;
        irq_ack_i = 1'b0;
        seen_passed = 1'b0;
        seen_failed = 1'b0;
        seen_exit = 1'b0;
        seen_exit_value = '0;
        repeat (3) @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_ni = 1'b1;
        check_reset_state();
        test_ram_access();
        test_instr_fetch();
        test_debug_remap();
        test_status_exit();
        test_timer_irq();
        test_debug_req();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

//--- src/mm_ram.sv
// Memory model top level
// Dual-port RAM for a RISC-V core with debug remap, test status and exit
// words, a timer interrupt and a debug request generator

`timescale 1ns/1ps

module mm_ram (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  mm_ram_pkg::word_t        dm_halt_addr_i,

    input  logic                     instr_req_i,
    input  mm_ram_pkg::word_t        instr_addr_i,
    output mm_ram_pkg::instr_line_t  instr_rdata_o,
    output logic                     instr_rvalid_o,
    output logic                     instr_gnt_o,

    input  logic                     data_req_i,
    input  mm_ram_pkg::word_t        data_addr_i,
    input  logic                     data_we_i,
    input  mm_ram_pkg::byte_en_t     data_be_i,
    input  mm_ram_pkg::word_t        data_wdata_i,
    output mm_ram_pkg::word_t        data_rdata_o,
    output logic                     data_rvalid_o,
    output logic                     data_gnt_o,

    input  mm_ram_pkg::irq_id_t      irq_id_i,
    input  logic                     irq_ack_i,
    output mm_ram_pkg::irq_vec_t     irq_o,

    output logic                     debug_req_o,
    output logic                     tests_passed_o,
    output logic                     tests_failed_o,
    output logic                     exit_valid_o,
    output mm_ram_pkg::word_t        exit_value_o
);

    import mm_ram_pkg::*;

    // RAM side of the decoder
    logic ram_instr_en;
    ram_addr_t ram_instr_addr;
    logic ram_data_en;
    logic ram_data_we;
    byte_en_t ram_data_be;
    ram_addr_t ram_data_addr;
    word_t ram_data_wdata;
    word_t ram_data_rdata;

    // peripheral writes and their strobes
    periph_e periph_sel;
    word_t periph_wdata;
    irq_vec_t timer_mask;
    logic timer_load;
    word_t timer_value;
    logic dbg_cmd_valid;
    word_t dbg_cmd;

    mm_addr_decoder mm_addr_decoder_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .dm_halt_addr_i   (dm_halt_addr_i),
        .instr_req_i      (instr_req_i),
        .instr_addr_i     (instr_addr_i),
        .data_req_i       (data_req_i),
        .data_addr_i      (data_addr_i),
        .data_we_i        (data_we_i),
        .data_be_i        (data_be_i),
        .data_wdata_i     (data_wdata_i),
        .ram_instr_en_o   (ram_instr_en),
        .ram_instr_addr_o (ram_instr_addr),
        .ram_data_en_o    (ram_data_en),
        .ram_data_we_o    (ram_data_we),
        .ram_data_be_o    (ram_data_be),
        .ram_data_addr_o  (ram_data_addr),
        .ram_data_wdata_o (ram_data_wdata),
        .ram_data_rdata_i (ram_data_rdata),
        .data_rdata_o     (data_rdata_o),
        .data_rvalid_o    (data_rvalid_o),
        .data_gnt_o       (data_gnt_o),
        .instr_rvalid_o   (instr_rvalid_o),
        .instr_gnt_o      (instr_gnt_o),
        .periph_sel_o     (periph_sel),
        .periph_wdata_o   (periph_wdata)
    );

    dp_ram dp_ram_i (
        .clk_i         (clk_i),
        .instr_en_i    (ram_instr_en),
        .instr_addr_i  (ram_instr_addr),
        .instr_rdata_o (instr_rdata_o),
        .data_en_i     (ram_data_en),
        .data_we_i     (ram_data_we),
        .data_be_i     (ram_data_be),
        .data_addr_i   (ram_data_addr),
        .data_wdata_i  (ram_data_wdata),
        .data_rdata_o  (ram_data_rdata)
    );

    // ---------------------------------------------------------------------------
    // pseudo-peripherals
    // ---------------------------------------------------------------------------

    mm_ctrl_regs mm_ctrl_regs_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .periph_sel_i    (periph_sel),
        .periph_wdata_i  (periph_wdata),
        .tests_passed_o  (tests_passed_o),
        .tests_failed_o  (tests_failed_o),
        .exit_valid_o    (exit_valid_o),
        .exit_value_o    (exit_value_o),
        .timer_mask_o    (timer_mask),
        .timer_load_o    (timer_load),
        .timer_value_o   (timer_value),
        .dbg_cmd_valid_o (dbg_cmd_valid),
        .dbg_cmd_o       (dbg_cmd)
    );

    irq_timer irq_timer_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .timer_mask_i  (timer_mask),
        .timer_load_i  (timer_load),
        .timer_value_i (timer_value),
        .irq_id_i      (irq_id_i),
        .irq_ack_i     (irq_ack_i),
        .irq_o         (irq_o)
    );

    debug_req_gen debug_req_gen_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .dbg_cmd_valid_i (dbg_cmd_valid),
        .dbg_cmd_i       (dbg_cmd),
        .debug_req_o     (debug_req_o)
    );

endmodule

//--- src/debug_req_gen.sv
// Debug request generator
// Drives debug_req_o to a requested level after a start delay and, in
// pulse mode, returns it to the inverse level after a set width

`timescale 1ns/1ps

module debug_req_gen (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              dbg_cmd_valid_i,
    input  mm_ram_pkg::word_t dbg_cmd_i,
    output logic              debug_req_o
);

    import mm_ram_pkg::*;

    // command word fields are 31 level, 30 pulse mode, 28:16 width and 14:0 delay
    dbg_state_e state_q;
    dbg_delay_t count_q;
    dbg_width_t width_q;
    logic level_q;
    logic pulse_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= DBG_IDLE;
            count_q <= '0;
            width_q <= '0;
            level_q <= 1'b0;
            pulse_q <= 1'b0;
            debug_req_o <= 1'b0;
        end else begin
            case (state_q)
                DBG_IDLE: begin
                    if (dbg_cmd_valid_i) begin
                        // zero delay or width counts as one
                        count_q <= (dbg_cmd_i[14:0] == '0) ? dbg_delay_t'(1) : dbg_cmd_i[14:0];
                        width_q <= (dbg_cmd_i[28:16] == '0) ? dbg_width_t'(1) : dbg_cmd_i[28:16];
                        level_q <= dbg_cmd_i[31];
                        pulse_q <= dbg_cmd_i[30];
                        state_q <= DBG_DELAY;
                    end
                end
                DBG_DELAY: begin
                    count_q <= count_q - 1'b1;
                    if (count_q == dbg_delay_t'(1)) begin
                        debug_req_o <= level_q;
                        if (pulse_q) begin
                            count_q <= dbg_delay_t'(width_q);
                            state_q <= DBG_HOLD;
                        end else begin
                            state_q <= DBG_IDLE;
                        end
                    end
                end
                DBG_HOLD: begin
                    count_q <= count_q - 1'b1;
                    if (count_q == dbg_delay_t'(1)) begin
                        debug_req_o <= !level_q;
                        state_q <= DBG_IDLE;
                    end
                end
                default: state_q <= DBG_IDLE;
            endcase
        end
    end

endmodule

//--- src/irq_timer.sv
// Interrupt timer
// Counts down from the loaded value and copies the mask into the
// interrupt vector when it expires. Acknowledge clears one bit

`timescale 1ns/1ps

module irq_timer (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  mm_ram_pkg::irq_vec_t timer_mask_i,
    input  logic                 timer_load_i,
    input  mm_ram_pkg::word_t    timer_value_i,
    input  mm_ram_pkg::irq_id_t  irq_id_i,
    input  logic                 irq_ack_i,
    output mm_ram_pkg::irq_vec_t irq_o
);

    import mm_ram_pkg::*;

    word_t count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (timer_load_i) begin
            count_q <= timer_value_i;
        end else if (count_q != '0) begin
            count_q <= count_q - 1'b1;
        end
    end

    // reload wins over an acknowledge in the same cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            irq_o <= '0;
        end else if (count_q == word_t'(1)) begin
            irq_o <= timer_mask_i;
        end else if (irq_ack_i) begin
            irq_o[irq_id_i] <= 1'b0;
        end
    end

endmodule

//--- src/mm_ctrl_regs.sv
// Control and status block
// Turns peripheral writes into test status pulses, the exit word, the
// timer mask register and the load strobes for the timer and debug unit

`timescale 1ns/1ps
`include "mm_ram_config.svh"

module mm_ctrl_regs (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  mm_ram_pkg::periph_e  periph_sel_i,
    input  mm_ram_pkg::word_t    periph_wdata_i,
    output logic                 tests_passed_o,
    output logic                 tests_failed_o,
    output logic                 exit_valid_o,
    output mm_ram_pkg::word_t    exit_value_o,
    output mm_ram_pkg::irq_vec_t timer_mask_o,
    output logic                 timer_load_o,
    output mm_ram_pkg::word_t    timer_value_o,
    output logic                 dbg_cmd_valid_o,
    output mm_ram_pkg::word_t    dbg_cmd_o
);

    import mm_ram_pkg::*;

    logic status_wr;
    irq_vec_t timer_mask_q;

    // status and exit are pulses in the write cycle
    assign status_wr = (periph_sel_i == PER_STATUS);
    assign tests_passed_o = status_wr && (periph_wdata_i == `MM_PASS_CODE);
    assign tests_failed_o = status_wr && (periph_wdata_i == `MM_FAIL_CODE);

    assign exit_valid_o = (periph_sel_i == PER_EXIT);
    assign exit_value_o = exit_valid_o ? periph_wdata_i : '0;

    // mask is sampled by the timer when the count expires
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_mask_q <= '0;
        end else if (periph_sel_i == PER_TIMER_MASK) begin
            timer_mask_q <= periph_wdata_i;
        end
    end

    assign timer_mask_o = timer_mask_q;

    // one-cycle load strobes for the timer and the debug generator
    assign timer_load_o = (periph_sel_i == PER_TIMER_VAL);
    assign timer_value_o = periph_wdata_i;

    assign dbg_cmd_valid_o = (periph_sel_i == PER_DEBUG);
    assign dbg_cmd_o = periph_wdata_i;

endmodule

//--- src/mm_addr_decoder.sv
// Address decoder for the memory model
// Remaps the debug region to the top of the RAM, steers data requests to
// the RAM or a pseudo-peripheral and produces the one-cycle responses

`timescale 1ns/1ps
`include "mm_ram_config.svh"

module mm_addr_decoder (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  mm_ram_pkg::word_t      dm_halt_addr_i,

    input  logic                   instr_req_i,
    input  mm_ram_pkg::word_t      instr_addr_i,
    input  logic                   data_req_i,
    input  mm_ram_pkg::word_t      data_addr_i,
    input  logic                   data_we_i,
    input  mm_ram_pkg::byte_en_t   data_be_i,
    input  mm_ram_pkg::word_t      data_wdata_i,

    output logic                   ram_instr_en_o,
    output mm_ram_pkg::ram_addr_t  ram_instr_addr_o,
    output logic                   ram_data_en_o,
    output logic                   ram_data_we_o,
    output mm_ram_pkg::byte_en_t   ram_data_be_o,
    output mm_ram_pkg::ram_addr_t  ram_data_addr_o,
    output mm_ram_pkg::word_t      ram_data_wdata_o,
    input  mm_ram_pkg::word_t      ram_data_rdata_i,

    output mm_ram_pkg::word_t      data_rdata_o,
    output logic                   data_rvalid_o,
    output logic                   data_gnt_o,
    output logic                   instr_rvalid_o,
    output logic                   instr_gnt_o,

    output mm_ram_pkg::periph_e    periph_sel_o,
    output mm_ram_pkg::word_t      periph_wdata_o
);

    import mm_ram_pkg::*;

    localparam word_t RAM_SIZE = word_t'(2**`MM_RAM_ADDR_WIDTH);
    localparam word_t DBG_SIZE = word_t'(2**`MM_DBG_ADDR_WIDTH);
    localparam ram_addr_t DBG_BASE = ram_addr_t'(RAM_SIZE - DBG_SIZE);

    logic data_is_ram;
    logic read_ram_q;
    logic data_rvalid_q;
    logic instr_rvalid_q;

    // offset compare avoids overflow of base plus size
    function automatic logic dbg_hit(word_t addr, word_t base);
        return (addr >= base) && ((addr - base) < DBG_SIZE);
    endfunction

    function automatic ram_addr_t map_addr(word_t addr, word_t base);
        if (dbg_hit(addr, base)) begin
            return ram_addr_t'(addr - base) + DBG_BASE;
        end
        return addr[`MM_RAM_ADDR_WIDTH-1:0];
    endfunction

    // every request is granted at once as there is no stall logic
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o = data_req_i;

    assign ram_instr_en_o = instr_req_i;
    assign ram_instr_addr_o = map_addr(instr_addr_i, dm_halt_addr_i);

    assign data_is_ram = dbg_hit(data_addr_i, dm_halt_addr_i) || (data_addr_i < RAM_SIZE);

    assign ram_data_en_o = data_req_i && data_is_ram;
    assign ram_data_we_o = data_we_i;
    assign ram_data_be_o = data_be_i;
    assign ram_data_addr_o = map_addr(data_addr_i, dm_halt_addr_i);
    assign ram_data_wdata_o = data_wdata_i;

    // ---------------------------------------------------------------------------
    // peripheral write decode
    // ---------------------------------------------------------------------------

    always_comb begin
        periph_sel_o = PER_NONE;
        if (data_req_i && data_we_i && !data_is_ram) begin
            case (data_addr_i)
                `MM_ADDR_STATUS:     periph_sel_o = PER_STATUS;
                `MM_ADDR_EXIT:       periph_sel_o = PER_EXIT;
                `MM_ADDR_TIMER_MASK: periph_sel_o = PER_TIMER_MASK;
                `MM_ADDR_TIMER_VAL:  periph_sel_o = PER_TIMER_VAL;
                `MM_ADDR_DEBUG:      periph_sel_o = PER_DEBUG;
                default:             periph_sel_o = PER_NONE;
            endcase
        end
    end

    assign periph_wdata_o = (periph_sel_o != PER_NONE) ? data_wdata_i : '0;

    // ---------------------------------------------------------------------------
    // response path
    // ---------------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            read_ram_q <= 1'b0;
            data_rvalid_q <= 1'b0;
            instr_rvalid_q <= 1'b0;
        end else begin
            read_ram_q <= data_req_i && !data_we_i && data_is_ram;
            data_rvalid_q <= data_req_i;
            instr_rvalid_q <= instr_req_i;
        end
    end

    // reads outside the RAM return zero
    assign data_rdata_o = read_ram_q ? ram_data_rdata_i : '0;
    assign data_rvalid_o = data_rvalid_q;
    assign instr_rvalid_o = instr_rvalid_q;

endmodule

//--- src/dp_ram.sv
// Dual-port RAM
// Byte array with a line-wide instruction read port and a 32-bit data
// port with byte-enabled writes, both with a synchronous read

`timescale 1ns/1ps
`include "mm_ram_config.svh"

module dp_ram (
    input  logic                     clk_i,
    input  logic                     instr_en_i,
    input  mm_ram_pkg::ram_addr_t    instr_addr_i,
    output mm_ram_pkg::instr_line_t  instr_rdata_o,
    input  logic                     data_en_i,
    input  logic                     data_we_i,
    input  mm_ram_pkg::byte_en_t     data_be_i,
    input  mm_ram_pkg::ram_addr_t    data_addr_i,
    input  mm_ram_pkg::word_t        data_wdata_i,
    output mm_ram_pkg::word_t        data_rdata_o
);

    import mm_ram_pkg::*;

    localparam int LINE_BYTES = `MM_INSTR_WIDTH / 8;
    localparam int LINE_SHIFT = $clog2(LINE_BYTES);

    logic [7:0] mem [0:2**`MM_RAM_ADDR_WIDTH-1];

    ram_addr_t instr_base;
    ram_addr_t data_base;

    // both ports ignore the low address bits
    assign instr_base = {instr_addr_i[`MM_RAM_ADDR_WIDTH-1:LINE_SHIFT], {LINE_SHIFT{1'b0}}};
    assign data_base = {data_addr_i[`MM_RAM_ADDR_WIDTH-1:2], 2'b00};

    // lowest address ends up in the lowest byte lane
    always_ff @(posedge clk_i) begin
        if (instr_en_i) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                instr_rdata_o[8*i +: 8] <= mem[instr_base + ram_addr_t'(i)];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (data_en_i) begin
            if (data_we_i) begin
                for (int i = 0; i < 4; i++) begin
                    if (data_be_i[i]) begin
                        mem[data_base + ram_addr_t'(i)] <= data_wdata_i[8*i +: 8];
                    end
                end
            end else begin
                for (int i = 0; i < 4; i++) begin
                    data_rdata_o[8*i +: 8] <= mem[data_base + ram_addr_t'(i)];
                end
            end
        end
    end

endmodule

//--- src/mm_ram_pkg.sv
// Memory model types
// Vector types for addresses, data, interrupts and debug fields, and the
// enums for the peripheral select and the debug request FSM

`include "mm_ram_config.svh"

package mm_ram_pkg;

    // data and address words
    typedef logic [31:0] word_t;
    typedef logic [`MM_RAM_ADDR_WIDTH-1:0] ram_addr_t;
    typedef logic [`MM_INSTR_WIDTH-1:0] instr_line_t;
    typedef logic [3:0] byte_en_t;

    // interrupts
    typedef logic [31:0] irq_vec_t;
    typedef logic [4:0] irq_id_t;

    // debug command fields
    typedef logic [14:0] dbg_delay_t;
    typedef logic [12:0] dbg_width_t;

    // target of a data write outside the RAM
    typedef enum logic [2:0] {
        PER_NONE,
        PER_STATUS,
        PER_EXIT,
        PER_TIMER_MASK,
        PER_TIMER_VAL,
        PER_DEBUG
    } periph_e;

    typedef enum logic [1:0] {
        DBG_IDLE,
        DBG_DELAY,
        DBG_HOLD
    } dbg_state_e;

endpackage

//--- include/mm_ram_config.svh
// Memory model configuration
// Widths of the RAM and its ports, pseudo-peripheral addresses and the
// status codes that the test program writes

`ifndef MM_RAM_CONFIG_SVH
`define MM_RAM_CONFIG_SVH

// ---------------------------------------------------------------------------
// memory geometry
// ---------------------------------------------------------------------------

// byte address width of the RAM
`define MM_RAM_ADDR_WIDTH 16

// debug region is 2**14 bytes at the top of the RAM
`define MM_DBG_ADDR_WIDTH 14

// one instruction fetch returns a full line
`define MM_INSTR_WIDTH 128

// ---------------------------------------------------------------------------
// pseudo-peripheral addresses
// ---------------------------------------------------------------------------

`define MM_ADDR_STATUS 32'h2000_0000
`define MM_ADDR_EXIT 32'h2000_0004

`define MM_ADDR_TIMER_MASK 32'h1500_0000
`define MM_ADDR_TIMER_VAL 32'h1500_0004

// debug command word whose fields debug_req_gen decodes
`define MM_ADDR_DEBUG 32'h1500_0008

// ---------------------------------------------------------------------------
// test status codes
// ---------------------------------------------------------------------------

`define MM_PASS_CODE 32'd123456789
`define MM_FAIL_CODE 32'd1

`endif
